// File: src/mips_pkg.sv
package mips_pkg;

    localparam int xlen = 32;
    localparam int nreg = 32;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_lui = 3'd5
    } alu_op_e;

    // none must stay zero so that a cleared payload is a bubble.
    typedef enum logic [1:0] {
        acc_none    = 2'd0,
        acc_load    = 2'd1,
        acc_store_w = 2'd2,
        acc_store_b = 2'd3
    } access_e;

    // ********************
    // opcodes and functs.
    // ********************
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    localparam logic [xlen-1:0] nop_word = 32'h0;

    // ********************
    // bus and stage payloads.
    // ********************
    typedef struct packed {
        logic [xlen-1:0] address;
        logic [3:0]      byteenable;
        logic            read;
        logic            write;
        logic [xlen-1:0] wrdata;
    } bus_req_t;

    typedef struct packed {
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
    } if_id_t;

    typedef struct packed {
        alu_op_e         alu_op;
        logic            use_imm;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rs_val;
        logic [xlen-1:0] rt_val;
        reg_addr_t       dest;
        access_e         access;
        reg_addr_t       rt_idx;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [xlen-1:0] store_data;
        reg_addr_t       dest;
        access_e         access;
    } ex_mm_t;

    // dest of zero means no register write.
    typedef struct packed {
        logic [xlen-1:0] wdata;
        reg_addr_t       dest;
    } mm_wb_t;

    typedef struct packed {
        reg_addr_t       dest;
        logic [xlen-1:0] value;
    } fwd_src_t;

endpackage

// File: src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en_i,
    input  logic        redirect_i,
    input  logic [31:0] target_i,
    output logic [31:0] pc_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o <= 32'h0;
        end else if (en_i) begin
            if (redirect_i) begin
                pc_o <= target_i;
            end else begin
                pc_o <= pc_o + 32'd4;
            end
        end
    end

    // targets come from decode, so alignment is a whole-core property.
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n) pc_o[1:0] == 2'b00
    );

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  mips_pkg::reg_addr_t raddr_a_i,
    input  mips_pkg::reg_addr_t raddr_b_i,
    output logic [31:0]       rdata_a_o,
    output logic [31:0]       rdata_b_o,
    input  mips_pkg::mm_wb_t  wb_i
);

    import mips_pkg::*;

    logic [xlen-1:0] regs [nreg];

    always_ff @(posedge clk) begin
        if (wb_i.dest != '0) begin
            regs[wb_i.dest] <= wb_i.wdata;
        end
    end

    // r0 reads as zero whatever the array holds.
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    // writeback data has crossed every stage by now.
    a_wb_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_i.dest != '0 |-> !$isunknown(wb_i.wdata)
    );

endmodule

// File: src/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic [31:0]         inst_i,
    input  logic [31:0]         pc_i,
    output mips_pkg::reg_addr_t rs_o,
    output mips_pkg::reg_addr_t rt_o,
    input  logic [31:0]         rs_val_i,
    input  logic [31:0]         rt_val_i,
    output mips_pkg::id_ex_t    ctrl_o,
    output logic                redirect_o,
    output logic [31:0]         target_o
);

    import mips_pkg::*;

    logic [5:0]      opcode;
    logic [5:0]      funct;
    reg_addr_t       rd;
    logic [15:0]     imm16;
    logic [25:0]     index;
    logic [xlen-1:0] imm_sext;
    logic [xlen-1:0] imm_zext;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] j_target;
    logic            ops_equal;
    logic            is_nop;
    logic            valid;

    assign opcode = inst_i[31:26];
    assign rs_o   = inst_i[25:21];
    assign rt_o   = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];
    assign index  = inst_i[25:0];

    assign imm_sext = {{16{imm16[15]}}, imm16};
    assign imm_zext = {16'h0, imm16};

    // targets are relative to the delay slot.
    assign pc_plus4  = pc_i + 32'd4;
    assign br_target = pc_plus4 + {imm_sext[xlen-3:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], index, 2'b00};

    assign ops_equal = (rs_val_i == rt_val_i);
    assign is_nop    = (inst_i == nop_word);

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.rs_val = rs_val_i;
        ctrl_o.rt_val = rt_val_i;
        ctrl_o.rt_idx = rt_o;
        ctrl_o.imm    = imm_sext;
        valid         = 1'b1;
        redirect_o    = 1'b0;
        target_o      = br_target;
        case (opcode)
            op_special: begin
                ctrl_o.dest = rd;
                case (funct)
                    fn_addu: ctrl_o.alu_op = alu_add;
                    fn_subu: ctrl_o.alu_op = alu_sub;
                    fn_and:  ctrl_o.alu_op = alu_and;
                    fn_or:   ctrl_o.alu_op = alu_or;
                    fn_slt:  ctrl_o.alu_op = alu_slt;
                    default: valid = 1'b0;
                endcase
            end
            op_addiu: begin
                ctrl_o.alu_op  = alu_add;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.dest    = rt_o;
            end
            op_ori: begin
                ctrl_o.alu_op  = alu_or;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.imm     = imm_zext;
                ctrl_o.dest    = rt_o;
            end
            op_lui: begin
                ctrl_o.alu_op  = alu_lui;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.imm     = imm_zext;
                ctrl_o.dest    = rt_o;
            end
            op_lw: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.dest    = rt_o;
                ctrl_o.access  = acc_load;
            end
            op_sw: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.access  = acc_store_w;
            end
            op_sb: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.access  = acc_store_b;
            end
            op_beq: redirect_o = ops_equal;
            op_bne: redirect_o = !ops_equal;
            op_j: begin
                redirect_o = 1'b1;
                target_o   = j_target;
            end
            default: valid = 1'b0;
        endcase
        // unknown words go down the pipe as bubbles.
        if (!valid || is_nop) begin
            ctrl_o     = '0;
            redirect_o = 1'b0;
        end
    end

endmodule

// File: src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // an all-zero payload is a bubble in every stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= '0;
        end else if (bubble_i) begin
            q_o <= '0;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

// File: src/fwd_mux.sv
`timescale 1ns/1ps

module fwd_mux (
    input  mips_pkg::reg_addr_t idx_i,
    input  logic [31:0]         rf_val_i,
    input  mips_pkg::fwd_src_t  ex_i,
    input  mips_pkg::fwd_src_t  mm_i,
    input  mips_pkg::fwd_src_t  wb_i,
    input  logic                ex_is_load_i,
    output logic [31:0]         val_o
);

    logic live;

    assign live = (idx_i != '0);

    // youngest producer wins.
    always_comb begin
        if (live && ex_i.dest == idx_i && !ex_is_load_i) begin
            val_o = ex_i.value;
        end else if (live && mm_i.dest == idx_i) begin
            val_o = mm_i.value;
        end else if (live && wb_i.dest == idx_i) begin
            val_o = wb_i.value;
        end else begin
            val_o = rf_val_i;
        end
    end

endmodule

// File: src/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
    input  mips_pkg::id_ex_t ctrl_i,
    output mips_pkg::ex_mm_t out_o
);

    import mips_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;
    logic            less;

    assign op_a = ctrl_i.rs_val;
    assign op_b = ctrl_i.use_imm ? ctrl_i.imm : ctrl_i.rt_val;
    assign less = ($signed(op_a) < $signed(op_b));

    always_comb begin
        case (ctrl_i.alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_slt: result = {{(xlen-1){1'b0}}, less};
            alu_lui: result = {op_b[15:0], 16'h0};
            default: result = op_a + op_b;
        endcase
    end

    // the sum doubles as the effective address for loads and stores.
    always_comb begin
        out_o            = '0;
        out_o.result     = result;
        out_o.store_data = ctrl_i.rt_val;
        out_o.dest       = ctrl_i.dest;
        out_o.access     = ctrl_i.access;
    end

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  mips_pkg::ex_mm_t  in_i,
    output mips_pkg::bus_req_t dbus_req_o,
    input  logic [31:0]       dbus_rddata_i,
    output mips_pkg::mm_wb_t  out_o
);

    import mips_pkg::*;

    always_comb begin
        dbus_req_o         = '0;
        dbus_req_o.address = in_i.result;
        out_o              = '0;
        out_o.dest         = in_i.dest;
        out_o.wdata        = in_i.result;
        case (in_i.access)
            acc_load: begin
                dbus_req_o.read       = 1'b1;
                dbus_req_o.byteenable = 4'hf;
                out_o.wdata           = dbus_rddata_i;
            end
            acc_store_w: begin
                dbus_req_o.write      = 1'b1;
                dbus_req_o.byteenable = 4'hf;
                dbus_req_o.wrdata     = in_i.store_data;
            end
            acc_store_b: begin
                // byte goes on every lane, one enable picks it.
                dbus_req_o.write      = 1'b1;
                dbus_req_o.byteenable = 4'b0001 << in_i.result[1:0];
                dbus_req_o.wrdata     = {4{in_i.store_data[7:0]}};
            end
            default: begin
                dbus_req_o.read  = 1'b0;
                dbus_req_o.write = 1'b0;
            end
        endcase
    end

    a_no_rd_wr : assert property (
        @(posedge clk) disable iff (!rst_n) !(dbus_req_o.read && dbus_req_o.write)
    );

    a_word_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        (dbus_req_o.read || (dbus_req_o.write && in_i.access == acc_store_w))
            |-> dbus_req_o.address[1:0] == 2'b00
    );

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::id_ex_t    ex_ctrl_i,
    input  mips_pkg::reg_addr_t rs_i,
    input  mips_pkg::reg_addr_t rt_i,
    output logic                en_pc_o,
    output logic                en_ifid_o,
    output logic                bubble_idex_o
);

    import mips_pkg::*;

    logic load_use;

    assign load_use = (ex_ctrl_i.access == acc_load) && (ex_ctrl_i.dest != '0) &&
                      (ex_ctrl_i.dest == rs_i || ex_ctrl_i.dest == rt_i);

    // freeze fetch and decode, send a bubble into execute.
    assign en_pc_o       = !load_use;
    assign en_ifid_o     = !load_use;
    assign bubble_idex_o = load_use;

    // the bubble clears execute, so the next cycle cannot stall again.
    a_one_cycle_stall : assert property (
        @(posedge clk) disable iff (!rst_n) bubble_idex_o |=> !bubble_idex_o
    );

endmodule

// File: src/naive_mips.sv
`timescale 1ns/1ps

module naive_mips (
    input  logic               clk,
    input  logic               rst_n,
    output mips_pkg::bus_req_t ibus_req_o,
    input  logic [31:0]        ibus_rddata_i,
    output mips_pkg::bus_req_t dbus_req_o,
    input  logic [31:0]        dbus_rddata_i
);

    import mips_pkg::*;

    logic            en_pc;
    logic            en_ifid;
    logic            bubble_idex;
    logic [xlen-1:0] if_pc;
    if_id_t          ifid_d;
    if_id_t          ifid_q;

    reg_addr_t       id_rs;
    reg_addr_t       id_rt;
    logic [xlen-1:0] rf_rs_val;
    logic [xlen-1:0] rf_rt_val;
    logic [xlen-1:0] id_rs_val;
    logic [xlen-1:0] id_rt_val;
    id_ex_t          id_ctrl;
    logic            id_redirect;
    logic [xlen-1:0] id_target;

    id_ex_t          ex_ctrl;
    ex_mm_t          ex_out;
    ex_mm_t          mm_in;
    mm_wb_t          mm_out;
    mm_wb_t          wb;

    fwd_src_t        ex_fwd;
    fwd_src_t        mm_fwd;
    fwd_src_t        wb_fwd;
    logic            ex_is_load;

    // ********************
    // fetch.
    // ********************
    assign ibus_req_o = '{address: if_pc, byteenable: 4'hf, read: 1'b1,
                          write: 1'b0, wrdata: '0};
    assign ifid_d     = '{inst: ibus_rddata_i, pc: if_pc};

    pc_unit i_pc_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .en_i       (en_pc),
        .redirect_i (id_redirect),
        .target_i   (id_target),
        .pc_o       (if_pc)
    );

    // id/ex always advances, so if/id only holds during a stall.
    stage_reg #(.payload_t(if_id_t)) i_ifid_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (en_ifid),
        .bubble_i (1'b0),
        .d_i      (ifid_d),
        .q_o      (ifid_q)
    );

    // ********************
    // decode.
    // ********************
    assign ex_fwd     = '{dest: ex_out.dest, value: ex_out.result};
    assign mm_fwd     = '{dest: mm_out.dest, value: mm_out.wdata};
    assign wb_fwd     = '{dest: wb.dest, value: wb.wdata};
    assign ex_is_load = (ex_ctrl.access == acc_load);

    reg_file i_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr_a_i (id_rs),
        .raddr_b_i (id_rt),
        .rdata_a_o (rf_rs_val),
        .rdata_b_o (rf_rt_val),
        .wb_i      (wb)
    );

    fwd_mux i_fwd_rs (
        .idx_i        (id_rs),
        .rf_val_i     (rf_rs_val),
        .ex_i         (ex_fwd),
        .mm_i         (mm_fwd),
        .wb_i         (wb_fwd),
        .ex_is_load_i (ex_is_load),
        .val_o        (id_rs_val)
    );

    fwd_mux i_fwd_rt (
        .idx_i        (id_rt),
        .rf_val_i     (rf_rt_val),
        .ex_i         (ex_fwd),
        .mm_i         (mm_fwd),
        .wb_i         (wb_fwd),
        .ex_is_load_i (ex_is_load),
        .val_o        (id_rt_val)
    );

    inst_decode i_inst_decode (
        .inst_i     (ifid_q.inst),
        .pc_i       (ifid_q.pc),
        .rs_o       (id_rs),
        .rt_o       (id_rt),
        .rs_val_i   (id_rs_val),
        .rt_val_i   (id_rt_val),
        .ctrl_o     (id_ctrl),
        .redirect_o (id_redirect),
        .target_o   (id_target)
    );

    hazard_unit i_hazard_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_ctrl_i     (ex_ctrl),
        .rs_i          (id_rs),
        .rt_i          (id_rt),
        .en_pc_o       (en_pc),
        .en_ifid_o     (en_ifid),
        .bubble_idex_o (bubble_idex)
    );

    // ********************
    // execute, memory, writeback.
    // ********************
    stage_reg #(.payload_t(id_ex_t)) i_idex_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (1'b1),
        .bubble_i (bubble_idex),
        .d_i      (id_ctrl),
        .q_o      (ex_ctrl)
    );

    alu_stage i_alu_stage (
        .ctrl_i (ex_ctrl),
        .out_o  (ex_out)
    );

    stage_reg #(.payload_t(ex_mm_t)) i_exmm_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (1'b1),
        .bubble_i (1'b0),
        .d_i      (ex_out),
        .q_o      (mm_in)
    );

    mem_stage i_mem_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_i          (mm_in),
        .dbus_req_o    (dbus_req_o),
        .dbus_rddata_i (dbus_rddata_i),
        .out_o         (mm_out)
    );

    stage_reg #(.payload_t(mm_wb_t)) i_mmwb_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .en_i     (1'b1),
        .bubble_i (1'b0),
        .d_i      (mm_out),
        .q_o      (wb)
    );

endmodule

// File: verification/naive_mips_tb.sv
`timescale 1ns/1ps

module naive_mips_tb;

    import mips_pkg::*;

    localparam int imem_words   = 1024;
    localparam int dmem_words   = 256;
    localparam int quiet_cycles = 20;

    logic            clk;
    logic            rst_n;
    bus_req_t        ibus_req;
    logic [xlen-1:0] ibus_rddata;
    bus_req_t        dbus_req;
    logic [xlen-1:0] dbus_rddata;

    logic [xlen-1:0] imem [imem_words];
    logic [xlen-1:0] dmem [dmem_words];
    bus_req_t        exp_stores [$];
    int              prog_len;
    int              cycle_limit;
    int              cycles;
    int              quiet;

    naive_mips i_naive_mips (
        .clk           (clk),
        .rst_n         (rst_n),
        .ibus_req_o    (ibus_req),
        .ibus_rddata_i (ibus_rddata),
        .dbus_req_o    (dbus_req),
        .dbus_rddata_i (dbus_rddata)
    );

    always #2 clk = ~clk;

    // ********************
    // failure paths.
    // ********************
    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "run aborted");
    endtask

    // ********************
    // compare tasks.
    // ********************
    task automatic check_dbus_write(input bus_req_t exp, input bus_req_t act);
        if (act.address !== exp.address || act.byteenable !== exp.byteenable ||
            act.wrdata !== exp.wrdata || act.read !== 1'b0) begin
            report_mismatch($sformatf(
                "dbus write expected addr %h be %h data %h, got addr %h be %h data %h rd %b",
                exp.address, exp.byteenable, exp.wrdata,
                act.address, act.byteenable, act.wrdata, act.read));
        end
    endtask

    task automatic check_idle(input bus_req_t act);
        if (act.read !== 1'b0 || act.write !== 1'b0) begin
            report_mismatch($sformatf("dbus expected idle, got read %b write %b",
                                      act.read, act.write));
        end
    endtask

    task automatic match_fetch(input bus_req_t act, input logic [xlen-1:0] exp_addr);
        if (act.address !== exp_addr || act.read !== 1'b1 || act.write !== 1'b0 ||
            act.byteenable !== 4'hf) begin
            report_mismatch($sformatf("ibus expected fetch at %h, got addr %h rd %b wr %b be %h",
                                      exp_addr, act.address, act.read, act.write,
                                      act.byteenable));
        end
    endtask

    // ********************
    // test file and bus models.
    // ********************
    task automatic load_tests();
        int              fd;
        int              code;
        logic [7:0]      kind;
        logic [xlen-1:0] w0;
        logic [xlen-1:0] w1;
        logic [xlen-1:0] w2;
        logic [xlen-1:0] w3;
        logic [3:0]      be;
        logic [8*128-1:0] line;
        bus_req_t        rec;
        fd = $fopen("verification/naive_mips_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/naive_mips_tests.txt");
        end
        code = $fscanf(fd, " %c", kind);
        while (code == 1) begin
            case (kind)
                "#": code = $fgets(line, fd);
                "P": begin
                    code = $fscanf(fd, "%h %h %h %h", w0, w1, w2, w3);
                    if (code != 4) begin
                        abort_run("malformed program line in test file");
                    end
                    imem[prog_len]     = w0;
                    imem[prog_len + 1] = w1;
                    imem[prog_len + 2] = w2;
                    imem[prog_len + 3] = w3;
                    prog_len += 4;
                end
                "D": begin
                    code = $fscanf(fd, "%h %h", w0, w1);
                    dmem[w0[9:2]] = w1;
                end
                "S": begin
                    code = $fscanf(fd, "%h %h %h", w0, be, w1);
                    rec            = '0;
                    rec.address    = w0;
                    rec.byteenable = be;
                    rec.write      = 1'b1;
                    rec.wrdata     = w1;
                    exp_stores.push_back(rec);
                end
                default: abort_run("unknown record kind in test file");
            endcase
            code = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
    endtask

    // stores land first, then both read ports follow the current addresses.
    task automatic serve_buses();
        logic [7:0] idx;
        idx = dbus_req.address[9:2];
        if (dbus_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (dbus_req.byteenable[b]) begin
                    dmem[idx][8*b +: 8] = dbus_req.wrdata[8*b +: 8];
                end
            end
        end
        ibus_rddata = imem[ibus_req.address[11:2]];
        dbus_rddata = dmem[idx];
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        ibus_rddata = nop_word;
        dbus_rddata = '0;
        prog_len    = 0;
        cycles      = 0;
        quiet       = 0;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = nop_word;
        end
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = ~(32'(i) << 2);
        end
        load_tests();
        cycle_limit = 4 * prog_len + 100;

        repeat (4) begin
            @(negedge clk);
            check_idle(dbus_req);
            match_fetch(ibus_req, 32'h0);
            serve_buses();
        end
        rst_n = 1'b1;

        while (quiet < quiet_cycles) begin
            @(negedge clk);
            cycles++;
            if (cycles >= cycle_limit) begin
                abort_run($sformatf("program did not finish within %0d cycles", cycle_limit));
            end
            if (dbus_req.write) begin
                if (exp_stores.size() == 0) begin
                    report_mismatch("dbus write with no expected store left");
                end else begin
                    check_dbus_write(exp_stores.pop_front(), dbus_req);
                end
            end else if (exp_stores.size() == 0) begin
                // the core now spins in its final self-loop.
                check_idle(dbus_req);
            end
            serve_buses();
            if (exp_stores.size() == 0) begin
                quiet++;
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: verification/naive_mips_tests.txt
# P: four program words, placed at consecutive word addresses from 0.
# D: byte address, initial data word.  S: byte address, byteenable, data, in store order.
P 3c011234 34215678 2402fffd 00221821
P 00222023 00222824 00223025 0041382a
P 0022402a ac010200 ac030204 ac040208
P ac05020c ac060210 ac070214 ac080218
P ac02021c 24090005 01295021 01495821
P 01696023 ac0c0220 ac0b0224 ac0a0228
P 8c0d0100 25ae0001 8c0f0104 ac0f022c
P ac0e0230 24100007 12090002 ac100234
P ac090238 16090002 ac0a023c ac0b0240
P 118a0002 ac0c0244 ac010248 158a0002
P 24110055 ac11024c 0800002d ac100250
P ac010254 241200a1 241300b2 a0120108
P a0130109 8c160108 ac160258 241400c3
P 241501d4 a014010a a015010b 8c170108
P ac17025c 1000ffff 00000000 00000000
D 00000100 00001234
D 00000104 abcd0000
D 00000108 11223344
# alu results.
S 00000200 f 12345678
S 00000204 f 12345675
S 00000208 f 1234567b
S 0000020c f 12345678
S 00000210 f fffffffd
S 00000214 f 00000001
S 00000218 f 00000000
S 0000021c f fffffffd
# forwarding chain.
S 00000220 f 0000000a
S 00000224 f 0000000f
S 00000228 f 0000000a
# load use.
S 0000022c f abcd0000
S 00000230 f 00001235
# branches and delay slots.
S 00000234 f 00000007
S 00000238 f 00000005
S 0000023c f 0000000a
S 00000244 f 0000000a
S 0000024c f 00000055
S 00000250 f 00000007
# byte stores and merged reads.
S 00000108 1 a1a1a1a1
S 00000109 2 b2b2b2b2
S 00000258 f 1122b2a1
S 0000010a 4 c3c3c3c3
S 0000010b 8 d4d4d4d4
S 0000025c f d4c3b2a1

// File: naive_mips.f
src/mips_pkg.sv
src/pc_unit.sv
src/reg_file.sv
src/inst_decode.sv
src/stage_reg.sv
src/fwd_mux.sv
src/alu_stage.sv
src/mem_stage.sv
src/hazard_unit.sv
src/naive_mips.sv
verification/naive_mips_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f naive_mips.f --top-module naive_mips_tb -Mdir obj_dir

./obj_dir/Vnaive_mips_tb 2>&1 | tee sim.log

if grep -q "All checks passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
